/* project.f */
verilog/cache_pkg.sv
verilog/cache_front_end.sv
verilog/cache_data_store.sv
verilog/cache_ctrl_regs.sv
verilog/cache_top.sv
tests/backend_mem_model.sv
tests/cache_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -j 0 \
   --top-module cache_tb -f project.f -o sim_cache \
   && ./obj_dir/sim_cache > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^Testbench passed$" sim.log \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

/* tests/backend_mem_model.sv */
`timescale 1ns/1ps

module backend_mem_model (
   input  logic                          clk_i,
   input  logic                          reset,
   input  cache_pkg::mem_req_t           mem_req,
   input  logic                          mem_valid,
   output logic                          mem_ack,
   output logic [cache_pkg::DATA_W-1:0]  mem_rdata
);
   import cache_pkg::*;

   logic [DATA_W-1:0] mem [logic [WORD_ADDR_W-1:0]];
   logic              busy;
   logic [2:0]        wait_cnt;
   logic [2:0]        delay;
   logic [31:0]       lfsr;
   logic [DATA_W-1:0] word;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // untouched words read back a pattern of their full address
   function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_ADDR_W-1:0] a);
      logic [31:0] wide;
      wide = {2'b00, a};
      return (wide * 32'h9e37_79b1) ^ (wide << 7);
   endfunction

   always @(posedge clk_i or posedge reset) begin
      if (reset) begin
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
         busy      <= 1'b0;
         wait_cnt  <= '0;
         lfsr       = 32'h14d1;
      end else begin
         mem_ack <= 1'b0;
         if (mem_valid && !mem_ack) begin
            if (!busy) begin
               // 3 bits of delay with one LFSR step each
               for (int i = 0; i < 3; i++) begin
                  lfsr     = lfsr_step(lfsr);
                  delay[i] = lfsr[0];
               end
               busy     <= 1'b1;
               wait_cnt <= delay;
            end else if (wait_cnt == 0) begin
               word = mem.exists(mem_req.addr) ? mem[mem_req.addr] : fill_word(mem_req.addr);
               if (mem_req.we) begin
                  for (int b = 0; b < NBYTES; b++) begin
                     if (mem_req.wstrb[b]) begin
                        word[8*b +: 8] = mem_req.wdata[8*b +: 8];
                     end
                  end
                  mem[mem_req.addr] = word;
               end
               mem_rdata <= word;
               mem_ack   <= 1'b1;
               busy      <= 1'b0;
            end else begin
               wait_cnt <= wait_cnt - 1'b1;
            end
         end
      end
   end

endmodule

/* tests/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
   import cache_pkg::*;

   localparam int INDEX_W = 4;
   localparam int LINES   = 2 ** INDEX_W;
   localparam int TIMEOUT = 200;
   localparam int N_OPS   = 60;

   logic              clk_i;
   logic              reset;
   host_req_t         host_req;
   logic              req;
   logic [DATA_W-1:0] rdata;
   logic              ack;
   logic              rvalid;
   logic              ready;
   mem_req_t          mem_req;
   mem_req_t          mem_req_prev;
   logic              mem_valid;
   logic              mem_ack;
   logic [DATA_W-1:0] mem_rdata;

   // expectations for the access in flight
   logic              started;
   logic              exp_read;
   logic [DATA_W-1:0] exp_rdata;
   int                exp_lat;
   logic              check_fill;
   logic              exp_fill;
   mem_req_t          exp_mem_req;
   int                cyc;
   int                req_cyc0;
   int                ack_count;
   int                ack_base;
   int                fill_count;
   int                fill_base;

   // reference model
   logic [31:0]            lfsr;
   logic [DATA_W-1:0]      ref_mem [logic [WORD_ADDR_W-1:0]];
   logic                   shadow_valid [LINES];
   logic [WORD_ADDR_W-1:0] shadow_tag [LINES];
   logic [31:0]            hits;
   logic [31:0]            misses;
   logic [31:0]            writes;

   cache_top #(
      .INDEX_W (INDEX_W)
   ) DUT (
      .clk_i     (clk_i),
      .reset     (reset),
      .host_req  (host_req),
      .req       (req),
      .rdata     (rdata),
      .ack       (ack),
      .rvalid    (rvalid),
      .ready     (ready),
      .mem_req   (mem_req),
      .mem_valid (mem_valid),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   backend_mem_model u_mem (
      .clk_i     (clk_i),
      .reset     (reset),
      .mem_req   (mem_req),
      .mem_valid (mem_valid),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   initial clk_i = 1'b0;
   always #2 clk_i = ~clk_i;

   // cycle and event counts
   always @(posedge clk_i or posedge reset) begin
      if (reset) begin
         cyc          <= 0;
         ack_count    <= 0;
         fill_count   <= 0;
         mem_req_prev <= '0;
      end else begin
         cyc          <= cyc + 1;
         mem_req_prev <= mem_req;
         if (ack) begin
            ack_count <= ack_count + 1;
         end
         if (mem_valid && !mem_req.we) begin
            fill_count <= fill_count + 1;
         end
      end
   end

   task automatic stop_fail();
      $display("Testbench failed");
      $fatal(1, "simulation stopped on error");
   endtask

   a_rdata: assert property (@(posedge clk_i) disable iff (reset)
      (ack && exp_read) |-> rdata == exp_rdata)
      else begin
         $display("ERR %0t rdata got %h exp %h", $time, rdata, exp_rdata);
         stop_fail();
      end

   a_rvalid: assert property (@(posedge clk_i) disable iff (reset)
      ack |-> rvalid == exp_read)
      else begin
         $display("ERR %0t rvalid got %0b exp %0b", $time, rvalid, exp_read);
         stop_fail();
      end

   a_latency: assert property (@(posedge clk_i) disable iff (reset)
      (ack && exp_lat != 0) |-> (cyc - req_cyc0) == exp_lat)
      else begin
         $display("ERR %0t ack latency got %0d exp %0d", $time, cyc - req_cyc0, exp_lat);
         stop_fail();
      end

   a_one_ack: assert property (@(posedge clk_i) disable iff (reset)
      ack |-> (req && ack_count == ack_base))
      else begin
         $display("ack seen without a pending request or twice for one request");
         stop_fail();
      end

   a_fill: assert property (@(posedge clk_i) disable iff (reset)
      (ack && check_fill) |-> ((fill_count != fill_base) == exp_fill))
      else begin
         $display("ERR %0t miss fill got %0b exp %0b", $time, fill_count != fill_base,
                  exp_fill);
         stop_fail();
      end

   a_write: assert property (@(posedge clk_i) disable iff (reset)
      (mem_valid && mem_req.we) |-> mem_req == exp_mem_req)
      else begin
         $display("ERR %0t mem_req got %h exp %h", $time, mem_req, exp_mem_req);
         stop_fail();
      end

   a_stable: assert property (@(posedge clk_i) disable iff (reset)
      (mem_valid && !mem_ack) |=> (mem_valid && mem_req == mem_req_prev))
      else begin
         $display("ERR %0t mem_req got %h exp %h", $time, mem_req, mem_req_prev);
         stop_fail();
      end

   a_stall: assert property (@(posedge clk_i) disable iff (reset)
      (mem_valid && !mem_ack) |-> (!ack && !rvalid && !ready))
      else begin
         $display("ack, rvalid or ready raised while the backend withheld mem_ack");
         stop_fail();
      end

   a_idle: assert property (@(posedge clk_i) disable iff (reset)
      !started |-> (!ack && !rvalid && !mem_valid && ready))
      else begin
         $display("ack, rvalid or mem_valid active or ready low before the first request");
         stop_fail();
      end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v[i] = lfsr[0];
      end
   endtask

   function automatic logic [DATA_W-1:0] ref_read(input logic [WORD_ADDR_W-1:0] w);
      logic [31:0] wide;
      wide = {2'b00, w};
      if (ref_mem.exists(w)) begin
         return ref_mem[w];
      end
      return (wide * 32'h9e37_79b1) ^ (wide << 7);
   endfunction

   // one host access held until ack
   task automatic access(input host_req_t r, input logic is_rd, input logic [DATA_W-1:0] erd,
                         input int lat, input logic chk, input logic efill);
      int n;
      @(posedge clk_i);
      #1;
      exp_read    = is_rd;
      exp_rdata   = erd;
      exp_lat     = lat;
      check_fill  = chk;
      exp_fill    = efill;
      exp_mem_req = {r.addr[ADDR_W-1:2], r.wdata, 1'b1, r.wstrb};
      req_cyc0    = cyc;
      ack_base    = ack_count;
      fill_base   = fill_count;
      host_req    = r;
      req         = 1'b1;
      started     = 1'b1;
      n = 0;
      @(negedge clk_i);
      while (!ack) begin
         n++;
         if (n > TIMEOUT) begin
            $display("timeout waiting for ack");
            stop_fail();
         end
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      req      = 1'b0;
      host_req = '0;
   endtask

   task automatic data_read(input logic [WORD_ADDR_W-1:0] w);
      host_req_t              r;
      logic [INDEX_W-1:0]     idx;
      logic [WORD_ADDR_W-1:0] tg;
      logic                   hit;
      idx = w[INDEX_W-1:0];
      tg  = w >> INDEX_W;
      hit = shadow_valid[idx] && (shadow_tag[idx] == tg);
      if (hit) begin
         hits++;
      end else begin
         misses++;
         shadow_valid[idx] = 1'b1;
         shadow_tag[idx]   = tg;
      end
      r = '0;
      r.addr = {1'b0, w, 2'b00};
      access(r, 1'b1, ref_read(w), hit ? 2 : 0, 1'b1, !hit);
   endtask

   // write through without allocate on miss
   task automatic data_write(input logic [WORD_ADDR_W-1:0] w, input logic [DATA_W-1:0] d,
                             input logic [NBYTES-1:0] strb);
      host_req_t         r;
      logic [DATA_W-1:0] word;
      word = ref_read(w);
      for (int b = 0; b < NBYTES; b++) begin
         if (strb[b]) begin
            word[8*b +: 8] = d[8*b +: 8];
         end
      end
      ref_mem[w] = word;
      writes++;
      r.addr  = {1'b0, w, 2'b00};
      r.wdata = d;
      r.wstrb = strb;
      access(r, 1'b0, '0, 0, 1'b1, 1'b0);
   endtask

   task automatic ctrl_access(input ctrl_reg_e sel, input logic is_wr,
                              input logic [DATA_W-1:0] erd);
      host_req_t r;
      r = '0;
      r.addr = {1'b1, {(ADDR_W - CTRL_ADDR_W){1'b0}}, sel};
      r.wstrb = is_wr ? '1 : '0;
      access(r, !is_wr, erd, 1, 1'b0, 1'b0);
   endtask

   task automatic check_counters();
      ctrl_access(CTRL_HITS, 1'b0, hits);
      ctrl_access(CTRL_MISSES, 1'b0, misses);
      ctrl_access(CTRL_WRITES, 1'b0, writes);
   endtask

   task automatic invalidate_all();
      ctrl_access(CTRL_INVALIDATE, 1'b1, '0);
      for (int i = 0; i < LINES; i++) begin
         shadow_valid[i] = 1'b0;
      end
      hits   = '0;
      misses = '0;
      writes = '0;
   endtask

   initial begin
      logic [31:0]            v;
      logic [31:0]            d;
      logic [WORD_ADDR_W-1:0] w;
      logic [WORD_ADDR_W-1:0] last_w;
      reset      = 1'b1;
      req        = 1'b0;
      host_req   = '0;
      started    = 1'b0;
      exp_read   = 1'b0;
      exp_rdata  = '0;
      exp_lat    = 0;
      check_fill = 1'b0;
      exp_fill   = 1'b0;
      exp_mem_req = '0;
      req_cyc0   = 0;
      ack_base   = 0;
      fill_base  = 0;
      lfsr       = 32'h14d1;
      hits       = '0;
      misses     = '0;
      writes     = '0;
      last_w     = '0;
      for (int i = 0; i < LINES; i++) begin
         shadow_valid[i] = 1'b0;
         shadow_tag[i]   = '0;
      end
      repeat (3) @(posedge clk_i);
      #1;
      reset = 1'b0;
      repeat (3) @(posedge clk_i);

      for (int i = 0; i < N_OPS; i++) begin
         // small tag range so lines get reused
         draw(INDEX_W + 2, v);
         w = '0;
         w[INDEX_W+1:0] = v[INDEX_W+1:0];
         draw(2, v);
         case (v[1:0])
            2'd2: begin
               draw(32, d);
               draw(NBYTES, v);
               data_write(w, d, (v[NBYTES-1:0] == 0) ? 4'h1 : v[NBYTES-1:0]);
            end
            2'd3: begin
               draw(32, d);
               draw(NBYTES, v);
               data_write(w, d, (v[NBYTES-1:0] == 0) ? 4'h8 : v[NBYTES-1:0]);
               data_read(w);
            end
            default: data_read(w);
         endcase
         last_w = w;
         if (i % 15 == 14) begin
            check_counters();
         end
         if (i == N_OPS / 2) begin
            data_read(last_w);
            invalidate_all();
            check_counters();
            data_read(last_w);
         end
      end
      check_counters();
      @(posedge clk_i);
      $display("Testbench passed");
      $finish;
   end

endmodule

/* verilog/cache_ctrl_regs.sv */
`timescale 1ns/1ps

module cache_ctrl_regs (
   input  logic                               clk_i,
   input  logic                               reset,
   input  logic                               ctrl_req,
   input  logic [cache_pkg::CTRL_ADDR_W-1:0]  ctrl_addr,
   input  logic                               ctrl_we,
   input  logic                               hit_pulse,
   input  logic                               miss_pulse,
   input  logic                               write_pulse,
   output logic                               ctrl_ack,
   output logic [cache_pkg::DATA_W-1:0]       ctrl_rdata,
   output logic                               invalidate_pulse
);
   import cache_pkg::*;

   localparam int NCNT = 3;

   logic                         access;
   logic                         inval_cmd;
   logic [NCNT-1:0]              cnt_inc;
   logic [NCNT-1:0][DATA_W-1:0]  cnt;

   // req is still high in the ack cycle, so skip it there
   assign access    = ctrl_req & ~ctrl_ack;
   assign inval_cmd = access & ctrl_we & (ctrl_addr == CTRL_INVALIDATE);

   // index order matches the register map
   assign cnt_inc = {write_pulse, miss_pulse, hit_pulse};

   // saturating event counters
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         cnt <= '0;
      end else if (inval_cmd) begin
         cnt <= '0;
      end else begin
         for (int i = 0; i < NCNT; i++) begin
            if (cnt_inc[i] && !(&cnt[i])) begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         ctrl_ack         <= 1'b0;
         invalidate_pulse <= 1'b0;
      end else begin
         ctrl_ack         <= access;
         invalidate_pulse <= inval_cmd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (access && !ctrl_we) begin
         case (ctrl_addr)
            CTRL_HITS:   ctrl_rdata <= cnt[CTRL_HITS];
            CTRL_MISSES: ctrl_rdata <= cnt[CTRL_MISSES];
            CTRL_WRITES: ctrl_rdata <= cnt[CTRL_WRITES];
            // invalidate is write only
            default:     ctrl_rdata <= '0;
         endcase
      end
   end

endmodule

/* verilog/cache_data_store.sv */
`timescale 1ns/1ps

module cache_data_store #(
   parameter int INDEX_W = 4
) (
   input  logic                          clk_i,
   input  logic                          reset,
   input  logic                          data_req_reg,
   input  cache_pkg::data_req_t          data_req_q,
   input  logic                          mem_ack,
   input  logic [cache_pkg::DATA_W-1:0]  mem_rdata,
   input  logic                          invalidate_pulse,
   output logic                          data_ack,
   output logic [cache_pkg::DATA_W-1:0]  data_rdata,
   output cache_pkg::mem_req_t           mem_req,
   output logic                          mem_valid,
   output logic                          hit_pulse,
   output logic                          miss_pulse,
   output logic                          write_pulse
);
   import cache_pkg::*;

   localparam int LINES  = 2 ** INDEX_W;
   localparam int OFFS_W = $clog2(NBYTES);
   localparam int TAG_W  = ADDR_W - OFFS_W - INDEX_W;

   store_state_e state;
   store_state_e state_nxt;

   logic [LINES-1:0]   valid_q;
   logic [TAG_W-1:0]   tag_mem  [LINES];
   logic [DATA_W-1:0]  data_mem [LINES];

   logic [INDEX_W-1:0] index;
   logic [TAG_W-1:0]   tag;
   logic               is_read;
   logic               hit;
   logic               fill_done;
   logic               write_done;

   // address split
   assign index   = data_req_q.addr[OFFS_W +: INDEX_W];
   assign tag     = data_req_q.addr[ADDR_W-1 -: TAG_W];
   assign is_read = ~|data_req_q.wstrb;
   assign hit     = valid_q[index] & (tag_mem[index] == tag);

   assign fill_done  = (state == ST_FILL) & mem_ack;
   assign write_done = (state == ST_WRITE) & mem_ack;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt   = state;
      data_ack    = 1'b0;
      hit_pulse   = 1'b0;
      miss_pulse  = 1'b0;
      write_pulse = 1'b0;
      case (state)
         ST_IDLE: begin
            if (data_req_reg) begin
               state_nxt = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (!is_read) begin
               write_pulse = 1'b1;
               state_nxt   = ST_WRITE;
            end else if (hit) begin
               hit_pulse = 1'b1;
               data_ack  = 1'b1;
               state_nxt = ST_IDLE;
            end else begin
               miss_pulse = 1'b1;
               state_nxt  = ST_FILL;
            end
         end
         ST_FILL, ST_WRITE: begin
            // both wait on the backend
            if (mem_ack) begin
               data_ack  = 1'b1;
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   // a fill returns the backend word directly
   assign data_rdata = (state == ST_FILL) ? mem_rdata : data_mem[index];

   // backend request held from the registered copy
   assign mem_valid     = (state == ST_FILL) | (state == ST_WRITE);
   assign mem_req.addr  = data_req_q.addr[ADDR_W-1:OFFS_W];
   assign mem_req.wdata = data_req_q.wdata;
   assign mem_req.we    = (state == ST_WRITE);
   assign mem_req.wstrb = data_req_q.wstrb;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         valid_q <= '0;
      end else if (invalidate_pulse) begin
         valid_q <= '0;
      end else if (fill_done) begin
         valid_q[index] <= 1'b1;
      end
   end

   // write miss leaves the line alone
   always_ff @(posedge clk_i) begin
      if (fill_done) begin
         tag_mem[index]  <= tag;
         data_mem[index] <= mem_rdata;
      end else if (write_done && hit) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (data_req_q.wstrb[b]) begin
               data_mem[index][8*b +: 8] <= data_req_q.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

/* verilog/cache_front_end.sv */
`timescale 1ns/1ps

module cache_front_end (
   input  logic                               clk_i,
   input  logic                               reset,
   input  cache_pkg::host_req_t               host_req,
   input  logic                               req,
   output logic [cache_pkg::DATA_W-1:0]       rdata,
   output logic                               ack,
   output logic                               rvalid,
   output logic                               ready,
   output logic                               data_req_reg,
   output cache_pkg::data_req_t               data_req_q,
   input  logic                               data_ack,
   input  logic [cache_pkg::DATA_W-1:0]       data_rdata,
   output logic                               ctrl_req,
   output logic [cache_pkg::CTRL_ADDR_W-1:0]  ctrl_addr,
   output logic                               ctrl_we,
   input  logic                               ctrl_ack,
   input  logic [cache_pkg::DATA_W-1:0]       ctrl_rdata
);
   import cache_pkg::*;

   logic ctrl_sel;
   logic data_req_int;
   logic data_ready;
   logic data_ready_nxt;
   logic capture;
   logic is_read;
   logic read_flag;

   // address space decode
   assign ctrl_sel     = host_req.addr[ADDR_W];
   assign data_req_int = req & ~ctrl_sel;
   assign ctrl_req     = req & ctrl_sel;
   assign ctrl_addr    = host_req.addr[CTRL_ADDR_W-1:0];
   assign ctrl_we      = |host_req.wstrb;
   assign is_read      = ~|host_req.wstrb;

   // take a new data request only while nothing is held
   assign capture = data_req_int & data_ready & ~data_req_reg;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         data_req_reg <= 1'b0;
      end else if (capture) begin
         data_req_reg <= 1'b1;
      end else if (data_ack) begin
         data_req_reg <= 1'b0;
      end
   end

   // held stable for the data store until the next capture
   always_ff @(posedge clk_i) begin
      if (capture) begin
         data_req_q.addr  <= host_req.addr[ADDR_W-1:0];
         data_req_q.wdata <= host_req.wdata;
         data_req_q.wstrb <= host_req.wstrb;
      end
   end

   // low from the cycle after a registered request until data_ack
   always_comb begin
      data_ready_nxt = ((data_req_reg | ~data_ready) & ~data_ack) ? 1'b0 : 1'b1;
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         data_ready <= 1'b1;
      end else begin
         data_ready <= data_ready_nxt;
      end
   end

   // remembers whether the access in flight is a read
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         read_flag <= 1'b0;
      end else if (capture | ctrl_req) begin
         read_flag <= is_read;
      end
   end

   // merge both ack paths
   assign ack    = ctrl_ack | data_ack;
   assign rdata  = ctrl_ack ? ctrl_rdata : data_rdata;
   assign rvalid = ack & read_flag;

   // control space never stalls
   assign ready  = ctrl_req | (data_ready & ~data_req_reg);

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

   // host side widths
   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;
   localparam int NBYTES      = DATA_W / 8;
   localparam int CTRL_ADDR_W = 3;

   // backend is addressed in words
   localparam int WORD_ADDR_W = ADDR_W - $clog2(NBYTES);

   // top addr bit selects the control space
   typedef struct packed {
      logic [ADDR_W:0]   addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } host_req_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [NBYTES-1:0] wstrb;
   } data_req_t;

   typedef struct packed {
      logic [WORD_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
      logic                   we;
      logic [NBYTES-1:0]      wstrb;
   } mem_req_t;

   typedef enum logic [CTRL_ADDR_W-1:0] {
      CTRL_HITS       = 3'd0,
      CTRL_MISSES     = 3'd1,
      CTRL_WRITES     = 3'd2,
      CTRL_INVALIDATE = 3'd3
   } ctrl_reg_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_FILL,
      ST_WRITE
   } store_state_e;

endpackage

/* verilog/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
   parameter int INDEX_W = 4
) (
   input  logic                          clk_i,
   input  logic                          reset,
   input  cache_pkg::host_req_t          host_req,
   input  logic                          req,
   output logic [cache_pkg::DATA_W-1:0]  rdata,
   output logic                          ack,
   output logic                          rvalid,
   output logic                          ready,
   output cache_pkg::mem_req_t           mem_req,
   output logic                          mem_valid,
   input  logic                          mem_ack,
   input  logic [cache_pkg::DATA_W-1:0]  mem_rdata
);
   import cache_pkg::*;

   // front end to data store
   logic                    data_req_reg;
   data_req_t               data_req_q;
   logic                    data_ack;
   logic [DATA_W-1:0]       data_rdata;

   // front end to control registers
   logic                    ctrl_req;
   logic [CTRL_ADDR_W-1:0]  ctrl_addr;
   logic                    ctrl_we;
   logic                    ctrl_ack;
   logic [DATA_W-1:0]       ctrl_rdata;

   // event and command strobes
   logic                    hit_pulse;
   logic                    miss_pulse;
   logic                    write_pulse;
   logic                    invalidate_pulse;

   cache_front_end u_front_end (
      .clk_i        (clk_i),
      .reset        (reset),
      .host_req     (host_req),
      .req          (req),
      .rdata        (rdata),
      .ack          (ack),
      .rvalid       (rvalid),
      .ready        (ready),
      .data_req_reg (data_req_reg),
      .data_req_q   (data_req_q),
      .data_ack     (data_ack),
      .data_rdata   (data_rdata),
      .ctrl_req     (ctrl_req),
      .ctrl_addr    (ctrl_addr),
      .ctrl_we      (ctrl_we),
      .ctrl_ack     (ctrl_ack),
      .ctrl_rdata   (ctrl_rdata)
   );

   cache_data_store #(
      .INDEX_W (INDEX_W)
   ) u_data_store (
      .clk_i            (clk_i),
      .reset            (reset),
      .data_req_reg     (data_req_reg),
      .data_req_q       (data_req_q),
      .mem_ack          (mem_ack),
      .mem_rdata        (mem_rdata),
      .invalidate_pulse (invalidate_pulse),
      .data_ack         (data_ack),
      .data_rdata       (data_rdata),
      .mem_req          (mem_req),
      .mem_valid        (mem_valid),
      .hit_pulse        (hit_pulse),
      .miss_pulse       (miss_pulse),
      .write_pulse      (write_pulse)
   );

   cache_ctrl_regs u_ctrl_regs (
      .clk_i            (clk_i),
      .reset            (reset),
      .ctrl_req         (ctrl_req),
      .ctrl_addr        (ctrl_addr),
      .ctrl_we          (ctrl_we),
      .hit_pulse        (hit_pulse),
      .miss_pulse       (miss_pulse),
      .write_pulse      (write_pulse),
      .ctrl_ack         (ctrl_ack),
      .ctrl_rdata       (ctrl_rdata),
      .invalidate_pulse (invalidate_pulse)
   );

endmodule
